//--- verilog.f
+incdir+include
verilog/seg7_pkg.sv
verilog/digitScanner.sv
verilog/glyphDecoder.sv
verilog/segmentDriver.sv
verilog/seg7Display.sv
tb/seg7Display_props.sv
tb/seg7Display_tb.sv

//--- Bender.yml
package:
  name: seg7_display

export_include_dirs:
  - include

sources:
  - verilog/seg7_pkg.sv
  - verilog/digitScanner.sv
  - verilog/glyphDecoder.sv
  - verilog/segmentDriver.sv
  - verilog/seg7Display.sv
  - target: test
    files:
      - tb/seg7Display_props.sv
      - tb/seg7Display_tb.sv

//--- tb/seg7Display_tb.sv
// Self-checking testbench for the display controller, run as the simulation top from verilog.f
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module seg7Display_tb;
    import seg7_pkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int slotCycles  = 4; // 2^scanBits with scanBits = 2
    localparam int scanCycles  = 4 * slotCycles;
    localparam int hexLoads    = 10;
    localparam int asciiLoads  = 12;
    localparam int brightSlots = 12;
    localparam int darkCycles  = 20;
    localparam int totalCycles = resetCycles + scanCycles + 2
        + (hexLoads + 2) * (scanCycles + 1) + (asciiLoads + 1) * (scanCycles + 1)
        + 4 * scanCycles + brightSlots * slotCycles + darkCycles + scanCycles;

    logic        clk = 1'b0;
    logic        rst;
    logic        load;
    logic        asciiMode;
    hexWord_t    hexIn;
    asciiWord_t  asciiIn;
    logic        enable;
    bright_t     bright;
    anodes_t     anodes;
    segments_t   segs;

    segments_t   hexTable [16];
    segments_t   asciiTable [128];
    logic [15:0] lfsrState = 16'd91;

    // reference model of the display pipeline
    charCode_t   modelCodes [4];
    logic        modelAscii;
    logic [3:0]  modelCnt;   // digit index in 3:2, phase in 1:0
    glyphSlot_t  modelSlot;
    anodes_t     expAnodes;
    segments_t   expSegs;
    logic        segsCare;   // low while no digit is selected
    int          anodeErrors = 0;
    int          segErrors = 0;

    seg7Display #(
        .scanBits (2)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .asciiMode (asciiMode),
        .hexIn     (hexIn),
        .asciiIn   (asciiIn),
        .enable    (enable),
        .bright    (bright),
        .anodes    (anodes),
        .segs      (segs)
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // half any byte, half the letter range
    function automatic charCode_t randomChar();
        if (randomBits(1) == 32'd1) begin
            return charCode_t'(randomBits(8));
        end
        return 8'h40 + charCode_t'(randomBits(6));
    endfunction

    function automatic segments_t refGlyph(input charCode_t code, input logic ascii);
        if (!ascii) begin
            return hexTable[code[3:0]];
        end
        if (code[7]) begin
            return `SEG7_BLANK;
        end
        return asciiTable[code[6:0]];
    endfunction

    task automatic buildTables();
        hexTable = '{7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
                     7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
                     7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
                     7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000};
        for (int i = 0; i < 128; i++) begin
            asciiTable[i] = `SEG7_BLANK;
        end
        for (int d = 0; d < 10; d++) begin
            asciiTable[8'h30 + d] = hexTable[d];
        end
        for (int l = 0; l < 6; l++) begin
            asciiTable[8'h41 + l] = hexTable[10 + l]; // A to F share the hex shapes
            asciiTable[8'h61 + l] = hexTable[10 + l];
        end
        asciiTable[8'h27] = 7'b1011111;
        asciiTable[8'h2D] = 7'b1111110;
        asciiTable[8'h3D] = 7'b1110110;
        asciiTable[8'h5F] = 7'b1110111;
        asciiTable[8'h47] = 7'b0000100;
        asciiTable[8'h48] = 7'b1001000;
        asciiTable[8'h49] = 7'b1001111;
        asciiTable[8'h4A] = 7'b1000011;
        asciiTable[8'h4C] = 7'b1110001;
        asciiTable[8'h4F] = 7'b0000001;
        asciiTable[8'h50] = 7'b0011000;
        asciiTable[8'h53] = 7'b0100100;
        asciiTable[8'h55] = 7'b1100011;
        asciiTable[8'h63] = 7'b1110010; // small c
        asciiTable[8'h67] = 7'b0000100;
        asciiTable[8'h68] = 7'b1101000;
        asciiTable[8'h69] = 7'b1001111;
        asciiTable[8'h6A] = 7'b1000011;
        asciiTable[8'h6C] = 7'b1001111;
        asciiTable[8'h6F] = 7'b1100010;
        asciiTable[8'h70] = 7'b0011000;
        asciiTable[8'h73] = 7'b0100100;
        asciiTable[8'h75] = 7'b1100011;
    endtask

    // advance the model by one rising edge, inputs as sampled at that edge
    task automatic stepModel();
        digitSel_t digit;
        if (rst) begin
            modelCnt = '0;
            modelCodes = '{default: '0};
            modelAscii = 1'b0;
            modelSlot.anodes = '1;
            modelSlot.segs = `SEG7_BLANK;
            modelSlot.phase = 2'd0;
            expAnodes = '1;
            expSegs = '1;
            segsCare = 1'b1;
        end else begin
            if (enable && modelSlot.phase <= bright) begin
                expAnodes = modelSlot.anodes;
                expSegs = modelSlot.segs;
                segsCare = (modelSlot.anodes != '1);
            end else begin
                expAnodes = '1;
                expSegs = `SEG7_BLANK;
                segsCare = 1'b1;
            end
            digit = modelCnt[3:2];
            modelSlot.anodes = ~(4'b0001 << digit);
            modelSlot.segs = refGlyph(modelCodes[digit], modelAscii);
            modelSlot.phase = modelCnt[1:0];
            modelCnt = modelCnt + 1'b1;
            if (load) begin
                modelAscii = asciiMode;
                for (int i = 0; i < 4; i++) begin
                    modelCodes[i] = asciiMode ? asciiIn[8*i +: 8] : {4'h0, hexIn[4*i +: 4]};
                end
            end
        end
    endtask

    // outputs have settled 1 ns after the edge, inputs move only on the falling edge
    always @(posedge clk) begin
        #1;
        stepModel();
        assert (anodes === expAnodes) else begin
            anodeErrors++;
            $display("mismatch at %0t: anodes got %b expected %b", $time, anodes, expAnodes);
        end
        if (segsCare) begin
            assert (segs === expSegs) else begin
                segErrors++;
                $display("mismatch at %0t: segs got %b expected %b", $time, segs, expSegs);
            end
        end
    end

    task automatic waitCycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic loadWord(input logic mode, input hexWord_t hexWord,
                            input asciiWord_t asciiWord);
        load = 1'b1;
        asciiMode = mode;
        hexIn = hexWord;
        asciiIn = asciiWord;
        @(negedge clk);
        load = 1'b0;
    endtask

    // inputs churn while load stays low
    task automatic scrambleInputs(input int count);
        repeat (count) begin
            hexIn = hexWord_t'(randomBits(16));
            asciiIn = randomBits(32);
            asciiMode = randomBits(1) == 32'd1;
            @(negedge clk);
        end
    endtask

    initial begin
        buildTables();
        rst = 1'b1;
        load = 1'b0;
        asciiMode = 1'b0;
        hexIn = '0;
        asciiIn = '0;
        enable = 1'b1;
        bright = 2'd3;
        waitCycles(resetCycles);
        rst = 1'b0;
        waitCycles(scanCycles + 2); // zeros on every digit
        loadWord(1'b0, 16'hFEDC, '0);
        scrambleInputs(scanCycles);
        loadWord(1'b0, 16'hBA98, '0);
        scrambleInputs(scanCycles);
        for (int i = 0; i < hexLoads; i++) begin
            loadWord(1'b0, hexWord_t'(randomBits(16)), randomBits(32));
            scrambleInputs(scanCycles);
        end
        loadWord(1'b1, '0, {8'h27, 8'h5F, 8'h3D, 8'h2D}); // dash on digit 0
        scrambleInputs(scanCycles);
        for (int i = 0; i < asciiLoads; i++) begin
            loadWord(1'b1, hexWord_t'(randomBits(16)),
                     {randomChar(), randomChar(), randomChar(), randomChar()});
            scrambleInputs(scanCycles);
        end
        for (int lvl = 0; lvl < 4; lvl++) begin
            bright = bright_t'(lvl);
            waitCycles(scanCycles);
        end
        for (int i = 0; i < brightSlots; i++) begin
            bright = bright_t'(randomBits(2));
            waitCycles(slotCycles);
        end
        bright = 2'd3;
        enable = 1'b0;
        waitCycles(darkCycles);
        enable = 1'b1;
        waitCycles(scanCycles);
        $display("errors: %0d anode, %0d segment, %0d protocol", anodeErrors, segErrors,
                 dut_i.props_i.assertFails);
        if (anodeErrors + segErrors + dut_i.props_i.assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #((totalCycles + 100) * clkPeriod);
        $display("timeout: stimulus still running after %0d cycles", totalCycles + 100);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/seg7Display_props.sv
// Output protocol assertions for the display controller, bound onto the top level in simulation
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module seg7Display_props (
    input logic                clk,
    input logic                rst,
    input logic                enable,
    input seg7_pkg::anodes_t   anodes,
    input seg7_pkg::segments_t segs
);

    int assertFails = 0; // failed property count

    // multiplexed digits, never two lit at once
    oneDigitLit: assert property (
        @(posedge clk) disable iff (rst)
        $countones(~anodes) <= 1
    ) else begin
        assertFails++;
        $error("more than one anode driven low: %b", anodes);
    end

    // first cycle out of reset stays dark
    resetDark: assert property (
        @(posedge clk)
        $past(rst) && !rst |=> anodes == '1
    ) else begin
        assertFails++;
        $error("a digit lit in the cycle after reset: %b", anodes);
    end

    // enable acts through the output register
    disabledBlank: assert property (
        @(posedge clk) disable iff (rst)
        $past(!enable) |-> (anodes == '1) && (segs == `SEG7_BLANK)
    ) else begin
        assertFails++;
        $error("display not blank one cycle after enable was low");
    end

endmodule

bind seg7Display seg7Display_props props_i (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .anodes (anodes),
    .segs   (segs)
);

`default_nettype wire

//--- verilog/seg7Display.sv
// Top of the four-digit display controller, wiring scanner, decoder and output driver
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module seg7Display #(
    parameter int scanBits = `SEG7_SCAN_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,      // one-cycle strobe
    input  logic                  asciiMode, // sampled with load
    input  seg7_pkg::hexWord_t    hexIn,
    input  seg7_pkg::asciiWord_t  asciiIn,
    input  logic                  enable,
    input  seg7_pkg::bright_t     bright,
    output seg7_pkg::anodes_t     anodes,
    output seg7_pkg::segments_t   segs
);
    import seg7_pkg::*;

    scanSlot_t  scanSlot;  // registered
    glyphSlot_t glyphSlot; // combinational

    digitScanner #(
        .scanBits (scanBits)
    ) scanner_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .asciiMode (asciiMode),
        .hexIn     (hexIn),
        .asciiIn   (asciiIn),
        .slot      (scanSlot)
    );

    glyphDecoder decoder_i (
        .slot  (scanSlot),
        .glyph (glyphSlot)
    );

    segmentDriver driver_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .bright (bright),
        .glyph  (glyphSlot),
        .anodes (anodes),
        .segs   (segs)
    );

endmodule

`default_nettype wire

//--- verilog/segmentDriver.sv
// Applies brightness and blanking to the decoded digit and registers the display pins
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module segmentDriver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  seg7_pkg::bright_t     bright,
    input  seg7_pkg::glyphSlot_t  glyph,
    output seg7_pkg::anodes_t     anodes,
    output seg7_pkg::segments_t   segs
);
    import seg7_pkg::*;

    logic      lit;
    anodes_t   nextAnodes;
    segments_t nextSegs;

    // digit on for phases 0..bright of its slot
    assign lit = enable && (glyph.phase <= bright);

    always_comb begin
        if (lit) begin
            nextAnodes = glyph.anodes;
            nextSegs   = glyph.segs;
        end else begin
            nextAnodes = '1;          // every digit off
            nextSegs   = `SEG7_BLANK;
        end
    end

    // pins only change on the clock edge
    always_ff @(posedge clk) begin
        if (rst) begin
            anodes <= '1;
            segs   <= '1;
        end else begin
            anodes <= nextAnodes;
            segs   <= nextSegs;
        end
    end

endmodule

`default_nettype wire

//--- verilog/glyphDecoder.sv
// Turns the scanned character code into active-low segments through the hex or ASCII table
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module glyphDecoder (
    input  seg7_pkg::scanSlot_t  slot,
    output seg7_pkg::glyphSlot_t glyph
);
    import seg7_pkg::*;

    // hex nibble to segments, abcdefg
    function automatic segments_t hexGlyph(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'hA: return 7'b0001000;
            4'hB: return 7'b1100000; // lower case b
            4'hC: return 7'b0110001;
            4'hD: return 7'b1000010; // lower case d
            4'hE: return 7'b0110000;
            default: return 7'b0111000; // F
        endcase
    endfunction

    // ASCII byte to segments, letters with no readable shape stay dark
    function automatic segments_t asciiGlyph(input charCode_t code);
        case (code)
            8'h27: return 7'b1011111; // apostrophe
            8'h2D: return 7'b1111110; // dash
            8'h3D: return 7'b1110110;
            8'h5F: return 7'b1110111; // underscore

            8'h30: return 7'b0000001;
            8'h31: return 7'b1001111;
            8'h32: return 7'b0010010;
            8'h33: return 7'b0000110;
            8'h34: return 7'b1001100;
            8'h35: return 7'b0100100;
            8'h36: return 7'b0100000;
            8'h37: return 7'b0001111;
            8'h38: return 7'b0000000;
            8'h39: return 7'b0000100;

            8'h41: return 7'b0001000; // A
            8'h42: return 7'b1100000; // b
            8'h43: return 7'b0110001;
            8'h44: return 7'b1000010; // d
            8'h45: return 7'b0110000;
            8'h46: return 7'b0111000;
            8'h47: return 7'b0000100; // looks like 9
            8'h48: return 7'b1001000;
            8'h49: return 7'b1001111; // same as 1
            8'h4A: return 7'b1000011;
            8'h4B: return `SEG7_BLANK;
            8'h4C: return 7'b1110001;
            8'h4D: return `SEG7_BLANK;
            8'h4E: return `SEG7_BLANK;
            8'h4F: return 7'b0000001; // same as 0
            8'h50: return 7'b0011000;
            8'h51: return `SEG7_BLANK;
            8'h52: return `SEG7_BLANK;
            8'h53: return 7'b0100100;
            8'h54: return `SEG7_BLANK;
            8'h55: return 7'b1100011; // small u
            8'h56: return `SEG7_BLANK;
            8'h57: return `SEG7_BLANK;
            8'h58: return `SEG7_BLANK;
            8'h59: return `SEG7_BLANK;
            8'h5A: return `SEG7_BLANK;

            8'h61: return 7'b0001000; // upper A
            8'h62: return 7'b1100000;
            8'h63: return 7'b1110010;
            8'h64: return 7'b1000010;
            8'h65: return 7'b0110000; // upper E
            8'h66: return 7'b0111000;
            8'h67: return 7'b0000100;
            8'h68: return 7'b1101000;
            8'h69: return 7'b1001111;
            8'h6A: return 7'b1000011;
            8'h6B: return `SEG7_BLANK;
            8'h6C: return 7'b1001111;
            8'h6D: return `SEG7_BLANK;
            8'h6E: return `SEG7_BLANK;
            8'h6F: return 7'b1100010;
            8'h70: return 7'b0011000;
            8'h71: return `SEG7_BLANK;
            8'h72: return `SEG7_BLANK;
            8'h73: return 7'b0100100;
            8'h74: return `SEG7_BLANK;
            8'h75: return 7'b1100011;
            8'h76: return `SEG7_BLANK;
            8'h77: return `SEG7_BLANK;
            8'h78: return `SEG7_BLANK;
            8'h79: return `SEG7_BLANK;
            8'h7A: return `SEG7_BLANK;

            default: return `SEG7_BLANK; // anything else is dark
        endcase
    endfunction

    always_comb begin
        glyph.anodes = slot.anodes;
        glyph.phase  = slot.phase;
        if (slot.asciiMode) begin
            glyph.segs = asciiGlyph(slot.code);
        end else if (slot.code[7:4] != 4'h0) begin
            glyph.segs = `SEG7_BLANK; // not a nibble
        end else begin
            glyph.segs = hexGlyph(slot.code[3:0]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/digitScanner.sv
// Holds the displayed word and scans the digits, feeding one code per slot to the decoder
`timescale 1ns/1ps
`default_nettype none

`include "seg7_cfg.svh"

module digitScanner #(
    parameter int scanBits = `SEG7_SCAN_BITS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   asciiMode,
    input  seg7_pkg::hexWord_t     hexIn,
    input  seg7_pkg::asciiWord_t   asciiIn,
    output seg7_pkg::scanSlot_t    slot
);
    import seg7_pkg::*;

    localparam int cntBits = scanBits + 2; // slot count plus digit index

    charCode_t [`SEG7_DIGITS-1:0] dispCodes;
    logic                         dispAscii;
    logic [cntBits-1:0]           refreshCnt;
    digitSel_t                    digitSel;
    logic [1:0]                   phase;
    anodes_t                      selAnodes;
    charCode_t                    selCode;

    // display register, loaded only on the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            dispCodes <= '0;
            dispAscii <= 1'b0;
        end else if (load) begin
            dispAscii <= asciiMode;
            if (asciiMode) begin
                dispCodes <= asciiIn; // bytes map straight onto codes
            end else begin
                for (int i = 0; i < `SEG7_DIGITS; i++) begin
                    dispCodes[i] <= {4'h0, hexIn[4*i +: 4]};
                end
            end
        end
    end

    // free-running refresh counter
    always_ff @(posedge clk) begin
        if (rst) begin
            refreshCnt <= '0;
        end else begin
            refreshCnt <= refreshCnt + 1'b1;
        end
    end

    assign digitSel = refreshCnt[cntBits-1 -: 2]; // top two bits
    assign phase    = refreshCnt[cntBits-3 -: 2]; // quarter within slot

    // one-cold anode for the scanned digit
    always_comb begin
        case (digitSel)
            2'd0: selAnodes = 4'b1110;
            2'd1: selAnodes = 4'b1101;
            2'd2: selAnodes = 4'b1011;
            default: selAnodes = 4'b0111;
        endcase
        selCode = dispCodes[digitSel];
    end

    // pipeline register toward the decoder
    always_ff @(posedge clk) begin
        if (rst) begin
            slot.anodes    <= '1; // all digits dark
            slot.code      <= '0;
            slot.asciiMode <= 1'b0;
            slot.phase     <= 2'd0;
        end else begin
            slot.anodes    <= selAnodes;
            slot.code      <= selCode;
            slot.asciiMode <= dispAscii;
            slot.phase     <= phase;
        end
    end

endmodule

`default_nettype wire

//--- verilog/seg7_pkg.sv
// Types shared by the seven-segment scanner, decoder and driver stages
`default_nettype none

`include "seg7_cfg.svh"

package seg7_pkg;

    // host-side words
    typedef logic [15:0] hexWord_t;   // digit 0 in bits 3:0
    typedef logic [31:0] asciiWord_t; // digit 0 in bits 7:0

    // one character code, hex nibbles are zero-extended
    typedef logic [7:0] charCode_t;

    // segment lines a..g from msb to lsb, active low
    typedef logic [6:0] segments_t;

    // digit enables, active low, bit 0 is the rightmost digit
    typedef logic [`SEG7_DIGITS-1:0] anodes_t;

    typedef logic [1:0] digitSel_t; // scanned digit index
    typedef logic [1:0] bright_t;   // lit for (level+1) quarters of a slot

    // registered by the scanner, consumed by the decoder
    typedef struct packed {
        anodes_t   anodes;
        charCode_t code;
        logic      asciiMode;
        logic [1:0] phase;  // quarter of the digit slot
    } scanSlot_t;

    // combinational output of the decoder
    typedef struct packed {
        anodes_t    anodes;
        segments_t  segs;
        logic [1:0] phase;
    } glyphSlot_t;

endpackage

`default_nettype wire

//--- include/seg7_cfg.svh
// Build-time settings for the seven-segment controller, included by the package and the RTL
`ifndef SEG7_CFG_SVH
`define SEG7_CFG_SVH

// number of multiplexed digits on the board
`define SEG7_DIGITS 4

// count width per digit slot, 2^16 cycles per digit at board clock
`define SEG7_SCAN_BITS 16

// all segments off, lines are active low
`define SEG7_BLANK 7'b1111111

`endif
